// File: files.f
src/cpu_sizes_pkg.sv
src/cpu_start_pkg.sv
src/start_sequencer.sv
src/start_manager.sv
src/word_mem.sv
src/start_unit_top.sv
verif/tb_checker.sv
verif/tb_top.sv

// File: run.sh
#!/bin/sh
# build and run the start unit testbench with verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary -j 0 --top-module tb_top -f files.f; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_top)
status=$?
echo "$out"

if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

# the pass line decides the result
if echo "$out" | grep -qx "TESTBENCH PASSED"; then
  exit 0
fi
exit 1

// File: src/cpu_sizes_pkg.sv
package cpu_sizes_pkg;

  // bus address, one word per address
  localparam int addr_width = 8;

  // data word, also the width of a command
  localparam int data_width = 32;

  // full address space is backed by memory
  localparam int mem_words = 256;

  // memory-mapped instruction pointer register
  // sits at the top word of the map
  localparam logic [addr_width-1:0] reg_ip_addr = 8'hff;

endpackage

// File: src/cpu_start_pkg.sv
package cpu_start_pkg;

  import cpu_sizes_pkg::*;

  // start-up sequence, in the order the sequencer walks it
  typedef enum logic [2:0] {
    start_idle       = 3'd0,
    start_begin      = 3'd1,
    start_read_cmd   = 3'd2,
    start_read_cmd_p = 3'd3,
    preexecute       = 3'd4,
    write_reg_ip     = 3'd5,
    start_done       = 3'd6
  } start_state_t;

  // request from the start manager, strobes last one cycle
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] wdata;
    logic                  read_q;
    logic                  write_q;
  } bus_req_t;

  // memory answer, one cycle after the strobe
  typedef struct packed {
    logic [data_width-1:0] rdata;
    logic                  read_dn;
    logic                  write_dn;
  } bus_rsp_t;

  // direct memory fill, only while the unit is idle
  typedef struct packed {
    logic [addr_width-1:0] addr;
    logic [data_width-1:0] data;
    logic                  valid;
  } mem_load_t;

endpackage

// File: src/start_manager.sv
module start_manager import cpu_sizes_pkg::*, cpu_start_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  start_state_t          state,
  input  logic                  disp_online,
  input  bus_rsp_t              bus_rsp,
  output bus_req_t              bus_req,
  output logic                  next_state,
  output logic [addr_width-1:0] cmd_ptr,
  output logic [data_width-1:0] command
);

  // states that do one bus access
  logic bus_state;
  // high until this state's request has gone out
  logic single;
  // request decided this cycle, visible on the bus next cycle
  logic issue;
  logic is_write;

  assign bus_state = (state == start_read_cmd) ||
                     (state == start_read_cmd_p) ||
                     (state == write_reg_ip);
  assign is_write = (state == write_reg_ip);

  // wait for the dispatcher before touching the bus
  assign issue = bus_state && disp_online && single;

  // state work finished
  // bus states end on their done strobe
  always_comb begin
    next_state = 1'b0;
    case (state)
      start_begin,
      preexecute: next_state = 1'b1;
      start_read_cmd,
      start_read_cmd_p: next_state = bus_rsp.read_dn;
      write_reg_ip: next_state = bus_rsp.write_dn;
      default: next_state = 1'b0;
    endcase
  end

  // re-armed on every state change
  always_ff @(posedge clk) begin
    if (rst) begin
      single <= 1'b1;
    end else if (next_state) begin
      single <= 1'b1;
    end else if (issue) begin
      single <= 1'b0;
    end
  end

  // request register, strobes clear themselves next cycle
  always_ff @(posedge clk) begin
    if (rst) begin
      bus_req.read_q  <= 1'b0;
      bus_req.write_q <= 1'b0;
    end else begin
      bus_req.read_q  <= issue && !is_write;
      bus_req.write_q <= issue && is_write;
      if (issue) begin
        // write-back always targets the ip register
        bus_req.addr  <= is_write ? reg_ip_addr : cmd_ptr;
        bus_req.wdata <= {{(data_width - addr_width){1'b0}}, cmd_ptr};
      end
    end
  end

  // pointer and command updates
  always_ff @(posedge clk) begin
    if (rst) begin
      cmd_ptr <= '0;
      command <= '0;
    end else begin
      case (state)
        // first read goes to the ip register
        start_begin: cmd_ptr <= reg_ip_addr;
        // ip value becomes the fetch pointer
        start_read_cmd: begin
          if (bus_rsp.read_dn) begin
            cmd_ptr <= bus_rsp.rdata[addr_width-1:0];
          end
        end
        start_read_cmd_p: begin
          if (bus_rsp.read_dn) begin
            command <= bus_rsp.rdata;
          end
        end
        // step past the fetched word, wraps at the top
        preexecute: cmd_ptr <= cmd_ptr + 1'b1;
        default: begin
        end
      endcase
    end
  end

endmodule

// File: src/start_sequencer.sv
module start_sequencer import cpu_start_pkg::*; (
  input  logic         clk,
  input  logic         rst,
  input  logic         go,
  input  logic         next_state,
  output start_state_t state,
  output logic         cmd_valid
);

  start_state_t state_nxt;

  // successor of each state
  // go only counts in idle, a go mid-start is dropped
  always_comb begin
    state_nxt = state;
    case (state)
      start_idle: begin
        if (go) begin
          state_nxt = start_begin;
        end
      end
      start_begin: begin
        if (next_state) begin
          state_nxt = start_read_cmd;
        end
      end
      start_read_cmd: begin
        if (next_state) begin
          state_nxt = start_read_cmd_p;
        end
      end
      start_read_cmd_p: begin
        if (next_state) begin
          state_nxt = preexecute;
        end
      end
      preexecute: begin
        if (next_state) begin
          state_nxt = write_reg_ip;
        end
      end
      write_reg_ip: begin
        if (next_state) begin
          state_nxt = start_done;
        end
      end
      // one cycle only, then back to idle
      start_done: state_nxt = start_idle;
      default: state_nxt = start_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= start_idle;
    end else begin
      state <= state_nxt;
    end
  end

  // fetch result is final while in start_done
  assign cmd_valid = (state == start_done);

endmodule

// File: src/start_unit_top.sv
module start_unit_top import cpu_sizes_pkg::*, cpu_start_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  logic                  disp_online,
  input  mem_load_t             load,
  output logic                  cmd_valid,
  output logic [data_width-1:0] command,
  output logic [addr_width-1:0] cmd_ptr
);

  start_state_t state;
  logic         next_state;
  bus_req_t     bus_req;
  bus_rsp_t     bus_rsp;

  // walks the start states
  start_sequencer i_seq (
    .clk        (clk),
    .rst        (rst),
    .go         (go),
    .next_state (next_state),
    .state      (state),
    .cmd_valid  (cmd_valid)
  );

  // does the per-state bus work
  start_manager i_mgr (
    .clk         (clk),
    .rst         (rst),
    .state       (state),
    .disp_online (disp_online),
    .bus_rsp     (bus_rsp),
    .bus_req     (bus_req),
    .next_state  (next_state),
    .cmd_ptr     (cmd_ptr),
    .command     (command)
  );

  // single-master word memory, ip register included
  word_mem i_mem (
    .clk     (clk),
    .load    (load),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp)
  );

endmodule

// File: src/word_mem.sv
module word_mem import cpu_sizes_pkg::*, cpu_start_pkg::*; (
  input  logic      clk,
  input  mem_load_t load,
  input  bus_req_t  bus_req,
  output bus_rsp_t  bus_rsp
);

  // contents only come from loads and writes
  logic [data_width-1:0] mem [mem_words];

  // load strobe wins over a write_q
  // loads only come while the unit is idle
  always_ff @(posedge clk) begin
    if (load.valid) begin
      mem[load.addr] <= load.data;
    end else if (bus_req.write_q) begin
      mem[bus_req.addr] <= bus_req.wdata;
    end
  end

  // rdata registered and valid together with read_dn
  always_ff @(posedge clk) begin
    if (bus_req.read_q) begin
      bus_rsp.rdata <= mem[bus_req.addr];
    end
  end

  // done strobes follow the request by one cycle
  always_ff @(posedge clk) begin
    bus_rsp.read_dn  <= bus_req.read_q;
    bus_rsp.write_dn <= bus_req.write_q;
  end

endmodule

// File: verif/start_testdata.txt
# L addr data  : load one memory word, both hex
# E cmd ptr    : expected command and new cmd_ptr of the next start, both hex
# S mode extra : go, mode 1 holds disp_online high, 0 drops it; extra > 0 repeats go then
L ff 00000010
L 10 a5a50001
L 11 a5a50002
L 12 a5a50003
E a5a50001 11
S 1 0
E a5a50002 12
S 1 4
E a5a50003 13
S 0 0
L ff 000000ff
E 000000ff 00
S 1 0
L 00 deadbeef
E deadbeef 01
S 0 11
L ff 000000fe
L fe 12345678
E 12345678 ff
S 1 0
E 000000ff 00
S 0 0
L ff abcd0020
L 20 0badf00d
E 0badf00d 21
S 1 0
L ff 123456ff
E 123456ff 00
S 1 11
L ff 00000040
L 40 cafe0040
L 41 cafe0041
E cafe0040 41
S 1 0
L ff 00000040
E cafe0040 41
S 0 0
E cafe0041 42
S 0 6

// File: verif/tb_checker.sv
module tb_checker import cpu_sizes_pkg::*, cpu_start_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  go,
  input  logic                  disp_online,
  input  mem_load_t             load,
  input  logic                  cmd_valid,
  input  logic [data_width-1:0] command,
  input  logic [addr_width-1:0] cmd_ptr,
  input  logic                  exp_valid,
  input  logic [data_width-1:0] exp_command,
  input  logic [addr_width-1:0] exp_ptr,
  output int                    value_errs,
  output int                    proto_errs
);

  // go cycle to cmd_valid cycle, both counted, dispatcher always online
  localparam int gapless_latency = 13;

  // mirror of the word memory
  logic [data_width-1:0] shadow [mem_words];
  logic                  busy;
  logic                  started;
  logic                  gapless;
  int                    cyc;
  logic [addr_width-1:0] ip;
  logic [data_width-1:0] pred_command;
  logic [addr_width-1:0] pred_ptr;
  // pending E record
  logic                  file_pending;
  logic [data_width-1:0] file_command;
  logic [addr_width-1:0] file_ptr;

  task automatic report_value(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
    $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    value_errs++;
  endtask

  task automatic report_issue(input string msg);
    $display("%0t %s", $time, msg);
    proto_errs++;
  endtask

  // end of a start, results are held during cmd_valid
  task automatic check_fetch();
    if (!busy) begin
      report_issue("cmd_valid with no go to answer");
      return;
    end
    busy = 1'b0;
    if (command !== pred_command) begin
      report_value("command", pred_command, command);
    end
    if (cmd_ptr !== pred_ptr) begin
      report_value("cmd_ptr", 32'(pred_ptr), 32'(cmd_ptr));
    end
    if (file_pending) begin
      if (command !== file_command) begin
        report_value("command vs file", file_command, command);
      end
      if (cmd_ptr !== file_ptr) begin
        report_value("cmd_ptr vs file", 32'(file_ptr), 32'(cmd_ptr));
      end
      file_pending = 1'b0;
    end else begin
      report_issue("start finished with no E record before it");
    end
    if (gapless && cyc != gapless_latency) begin
      report_value("latency", 32'(gapless_latency), 32'(cyc));
    end else if (cyc < gapless_latency) begin
      report_issue("start finished faster than the bus allows");
    end
    // unit wrote the stepped pointer back, upper bits zero
    shadow[reg_ip_addr] = {{(data_width - addr_width){1'b0}}, pred_ptr};
  endtask

  always @(posedge clk) begin
    if (rst) begin
      busy = 1'b0;
      started = 1'b0;
      gapless = 1'b1;
      cyc = 0;
      file_pending = 1'b0;
    end else begin
      if (load.valid) begin
        if (busy) begin
          report_issue("memory load while a start is running");
        end
        shadow[load.addr] = load.data;
      end
      if (exp_valid) begin
        if (file_pending) begin
          report_issue("two E records with no start between them");
        end
        file_command = exp_command;
        file_ptr = exp_ptr;
        file_pending = 1'b1;
      end
      // reset values hold until the first go
      if (!started) begin
        if (cmd_ptr !== '0) begin
          report_value("cmd_ptr", 32'd0, 32'(cmd_ptr));
        end
        if (command !== '0) begin
          report_value("command", 32'd0, command);
        end
      end
      if (busy) begin
        cyc++;
        if (!disp_online) begin
          gapless = 1'b0;
        end
      end
      // go outside idle is dropped by the unit
      if (go && !busy) begin
        busy = 1'b1;
        started = 1'b1;
        cyc = 1;
        gapless = 1'b1;
        // only the low byte of the ip register is a pointer
        ip = shadow[reg_ip_addr][addr_width-1:0];
        pred_command = shadow[ip];
        pred_ptr = ip + 1'b1;
      end
      if (cmd_valid) begin
        check_fetch();
      end
    end
  end

endmodule

// File: verif/tb_top.sv
module tb_top import cpu_sizes_pkg::*, cpu_start_pkg::*; ();

  localparam string data_file = "verif/start_testdata.txt";
  // cycles to wait for cmd_valid after one go
  localparam int start_limit = 60;
  // longest run of disp_online drops in a row
  localparam int max_drops = 3;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  go;
  logic                  disp_online;
  mem_load_t             load;
  logic                  cmd_valid;
  logic [data_width-1:0] command;
  logic [addr_width-1:0] cmd_ptr;

  // E record handed to the checker
  logic                  exp_valid;
  logic [data_width-1:0] exp_command;
  logic [addr_width-1:0] exp_ptr;

  int          value_errs;
  int          proto_errs;
  int          stim_errs;
  int          wd_cycles;
  logic [31:0] lcg_state;
  int          drop_run;

  start_unit_top i_dut (
    .clk         (clk),
    .rst         (rst),
    .go          (go),
    .disp_online (disp_online),
    .load        (load),
    .cmd_valid   (cmd_valid),
    .command     (command),
    .cmd_ptr     (cmd_ptr)
  );

  tb_checker i_chk (
    .clk         (clk),
    .rst         (rst),
    .go          (go),
    .disp_online (disp_online),
    .load        (load),
    .cmd_valid   (cmd_valid),
    .command     (command),
    .cmd_ptr     (cmd_ptr),
    .exp_valid   (exp_valid),
    .exp_command (exp_command),
    .exp_ptr     (exp_ptr),
    .value_errs  (value_errs),
    .proto_errs  (proto_errs)
  );

  initial begin
    forever #2 clk = ~clk;
  end

  // plain 32-bit lcg
  function automatic logic [31:0] next_random(input logic [31:0] x);
    return x * 32'd1664525 + 32'd1013904223;
  endfunction

  // mode 1 holds the dispatcher online
  // mode 0 drops it at random
  task automatic drive_online(input int mode);
    logic [31:0] r;
    if (mode == 1) begin
      disp_online = 1'b1;
      drop_run = 0;
    end else begin
      lcg_state = next_random(lcg_state);
      // low bit of the upper half decides a drop
      r = lcg_state >> 16;
      if (r[0] == 1'b0 && drop_run < max_drops) begin
        disp_online = 1'b0;
        drop_run++;
      end else begin
        disp_online = 1'b1;
        drop_run = 0;
      end
    end
  endtask

  task automatic load_word(input logic [addr_width-1:0] addr,
                           input logic [data_width-1:0] data);
    @(negedge clk);
    load.addr = addr;
    load.data = data;
    load.valid = 1'b1;
    @(negedge clk);
    load.valid = 1'b0;
  endtask

  task automatic expect_result(input logic [data_width-1:0] cmd,
                               input logic [addr_width-1:0] ptr);
    @(negedge clk);
    exp_command = cmd;
    exp_ptr = ptr;
    exp_valid = 1'b1;
    @(negedge clk);
    exp_valid = 1'b0;
  endtask

  // go strobe and an optional second go mid-start
  // then wait for cmd_valid
  task automatic start_fetch(input int mode, input int extra);
    int n;
    bit seen;
    @(negedge clk);
    go = 1'b1;
    drive_online(mode);
    n = 0;
    seen = 1'b0;
    while (!seen && n < start_limit) begin
      @(negedge clk);
      n++;
      seen = cmd_valid;
      go = (extra > 0 && n == extra);
      drive_online(mode);
    end
    go = 1'b0;
    disp_online = 1'b1;
    drop_run = 0;
    if (!seen) begin
      $display("%0t no cmd_valid within %0d cycles of go", $time, start_limit);
      stim_errs++;
    end
    // a stray cmd_valid would land in this quiet gap
    repeat (3) @(negedge clk);
  endtask

  // first pass over the file sizes the watchdog
  task automatic count_records(output int n_start, output int n_load);
    int fd;
    int n;
    string line;
    n_start = 0;
    n_load = 0;
    fd = $fopen(data_file, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0 && line.getc(0) == "S") begin
          n_start++;
        end else if (n > 0 && line.getc(0) == "L") begin
          n_load++;
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic print_counts();
    $display("errors: value %0d, protocol %0d, stimulus %0d",
             value_errs, proto_errs, stim_errs);
  endtask

  task automatic bad_record(input string line);
    $display("unreadable record in %s: %s", data_file, line);
    stim_errs++;
  endtask

  initial begin
    int          n_start;
    int          n_load;
    int          fd;
    int          n;
    int          mode;
    int          extra;
    string       line;
    string       rest;
    byte         kind;
    logic [31:0] a;
    logic [31:0] b;
    rst = 1'b1;
    go = 1'b0;
    disp_online = 1'b1;
    load = '0;
    exp_valid = 1'b0;
    exp_command = '0;
    exp_ptr = '0;
    stim_errs = 0;
    lcg_state = 32'h191d_b273;
    drop_run = 0;
    count_records(n_start, n_load);
    wd_cycles = 40 * n_start + 5 * n_load + 100;
    // two reset cycles
    repeat (2) @(negedge clk);
    rst = 1'b0;
    // idle stretch with no cmd_valid allowed
    repeat (5) @(negedge clk);
    fd = $fopen(data_file, "r");
    if (fd == 0) begin
      $display("cannot open stimulus file %s", data_file);
      stim_errs++;
    end else begin
      while (!$feof(fd)) begin
        n = $fgets(line, fd);
        if (n > 0) begin
          kind = line.getc(0);
          rest = line.substr(1, line.len() - 1);
          case (kind)
            "L": begin
              if ($sscanf(rest, "%h %h", a, b) == 2) begin
                load_word(a[addr_width-1:0], b);
              end else begin
                bad_record(line);
              end
            end
            "E": begin
              if ($sscanf(rest, "%h %h", a, b) == 2) begin
                expect_result(a, b[addr_width-1:0]);
              end else begin
                bad_record(line);
              end
            end
            "S": begin
              if ($sscanf(rest, "%d %d", mode, extra) == 2) begin
                start_fetch(mode, extra);
              end else begin
                bad_record(line);
              end
            end
            // comments and blank lines
            "#", " ", "\t", "\r", "\n": begin
            end
            default: bad_record(line);
          endcase
        end
      end
      $fclose(fd);
    end
    repeat (5) @(negedge clk);
    print_counts();
    if (value_errs + proto_errs + stim_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // watchdog limit follows the record counts
  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clk);
    $display("timeout, run still going after %0d cycles", wd_cycles);
    print_counts();
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule
